//--- include/ddr3_macros.svh
`ifndef DDR3_MACROS_SVH
`define DDR3_MACROS_SVH

// ***************************************************************************
// DDR3 user side sizes
// ***************************************************************************

// data word, one full burst
`define DDR3_WORD_BITS 128

// user address, 16-bit beat granularity
`define DDR3_ADDR_BITS 26

// burst address from the reader
`define DDR3_BURST_BITS 23

// eight 16-bit beats per 128-bit burst
`define DDR3_ADDR_STEP 8

// words per fill, header word included
`define DDR3_FILL_WORDS 4

// fill header fifo entries
`define DDR3_HDR_DEPTH 8

`endif

//--- verilog/ddr3_pkg.sv
`include "ddr3_macros.svh"

package ddr3_pkg;

	// one data word, as written to or read from DDR3
	typedef logic [`DDR3_WORD_BITS-1:0] ddr3_word_t;

	// user address
	typedef logic [`DDR3_ADDR_BITS-1:0] ddr3_addr_t;

	// controller address, top bit always zero
	typedef logic [`DDR3_ADDR_BITS:0] app_addr_t;

	// controller command encoding
	typedef enum logic [2:0] {
		APP_CMD_WRITE = 3'd0,
		APP_CMD_READ  = 3'd1
	} app_cmd_t;

endpackage

//--- verilog/ddr3_wr_control.sv
`include "ddr3_macros.svh"

module ddr3_wr_control import ddr3_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	// data fifo head
	input  ddr3_word_t ddr3_wr_dat,
	input  logic       ddr3_wr_fifo_empty,
	output logic       ddr3_wr_fifo_rd_en,
	// controller write data port
	input  logic       app_wdf_rdy,
	output logic       app_wdf_wren,
	output logic       app_wdf_end,
	// address control side
	input  logic       wr_addr_ack,
	output ddr3_addr_t ddr3_wr_addr,
	output logic       wr_request,
	output logic       wr_mode,
	// header fifo side
	input  logic       fill_header_full,
	output ddr3_word_t fill_header_wr_dat,
	output logic       fill_header_wr_en
);

	localparam int CNT_BITS = $clog2(`DDR3_FILL_WORDS);
	localparam int LAST_WORD = `DDR3_FILL_WORDS - 1;

	typedef enum logic [1:0] {WR_IDLE, WR_XFER, WR_POP} wr_state_t;

	wr_state_t           state;
	logic [CNT_BITS-1:0] word_cnt;
	logic                cmd_done;
	logic                data_done;
	logic                cmd_ok;
	logic                data_ok;
	logic                word_done;
	logic                start_ok;

	// command and data may be accepted in either order
	assign cmd_ok = cmd_done | wr_addr_ack;
	assign data_ok = data_done | (app_wdf_wren & app_wdf_rdy);
	assign word_done = (state == WR_XFER) & cmd_ok & data_ok;
	// only a header word waits for room in the header fifo
	assign start_ok = !ddr3_wr_fifo_empty && (word_cnt != '0 || !fill_header_full);

	// ***********************************************************************
	// word sequencer
	// ***********************************************************************
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= WR_IDLE;
			word_cnt <= '0;
			cmd_done <= 1'b0;
			data_done <= 1'b0;
			wr_request <= 1'b0;
			wr_mode <= 1'b0;
			app_wdf_wren <= 1'b0;
			app_wdf_end <= 1'b0;
			ddr3_wr_fifo_rd_en <= 1'b0;
			fill_header_wr_en <= 1'b0;
			ddr3_wr_addr <= '0;
		end else begin
			// pop and header strobes last one cycle
			ddr3_wr_fifo_rd_en <= 1'b0;
			fill_header_wr_en <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (start_ok) begin
						wr_request <= 1'b1;
						app_wdf_wren <= 1'b1;
						app_wdf_end <= 1'b1;
						cmd_done <= 1'b0;
						data_done <= 1'b0;
						// fill in progress, reads held off until the last word
						if (word_cnt == '0)
							wr_mode <= 1'b1;
						state <= WR_XFER;
					end
				end
				WR_XFER: begin
					if (wr_addr_ack) begin
						wr_request <= 1'b0;
						cmd_done <= 1'b1;
					end
					if (app_wdf_wren && app_wdf_rdy) begin
						app_wdf_wren <= 1'b0;
						app_wdf_end <= 1'b0;
						data_done <= 1'b1;
					end
					if (word_done) begin
						ddr3_wr_fifo_rd_en <= 1'b1;
						ddr3_wr_addr <= ddr3_wr_addr + ddr3_addr_t'(`DDR3_ADDR_STEP);
						if (word_cnt == '0)
							fill_header_wr_en <= 1'b1;
						if (word_cnt == LAST_WORD[CNT_BITS-1:0]) begin
							word_cnt <= '0;
							wr_mode <= 1'b0;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
						state <= WR_POP;
					end
				end
				// fifo head moves during this cycle
				WR_POP: state <= WR_IDLE;
				default: state <= WR_IDLE;
			endcase
		end
	end

	// header stamped with the address it was stored at
	always_ff @(posedge sysclk) begin
		if (word_done && word_cnt == '0)
			fill_header_wr_dat <= {ddr3_wr_dat[`DDR3_WORD_BITS-1:`DDR3_ADDR_BITS], ddr3_wr_addr};
	end

	// upstream fifo must hold a word whenever it is popped
	a_no_pop_empty: assert property (@(posedge sysclk) disable iff (reset)
		ddr3_wr_fifo_rd_en |-> !ddr3_wr_fifo_empty);

	// write data held until the controller takes it
	a_wren_held: assert property (@(posedge sysclk) disable iff (reset)
		app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(ddr3_wr_dat));

endmodule

//--- verilog/ddr3_rd_control.sv
`include "ddr3_macros.svh"

module ddr3_rd_control import ddr3_pkg::*; (
	input  logic                        sysclk,
	input  logic                        reset,
	// reader side
	input  logic [`DDR3_BURST_BITS-1:0] ddr3_rd_burst_addr,
	input  logic                        rd_one_burst,
	output logic                        one_burst_rdy,
	output ddr3_word_t                  ddr3_one_burst_data,
	// address control side
	input  logic                        rd_addr_ack,
	output ddr3_addr_t                  rd_addr,
	output logic                        rd_request,
	// controller read data port
	input  ddr3_word_t                  app_rd_data,
	input  logic                        app_rd_data_valid,
	input  logic                        app_rd_data_end
);

	typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} rd_state_t;

	rd_state_t state;
	logic      burst_start;
	logic      burst_land;

	assign burst_start = (state == RD_IDLE) && rd_one_burst;
	// single 128-bit beat, valid and end together
	assign burst_land = (state == RD_WAIT) && app_rd_data_valid && app_rd_data_end;

	// ***********************************************************************
	// one-burst read sequencer
	// ***********************************************************************
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= RD_IDLE;
			rd_request <= 1'b0;
			one_burst_rdy <= 1'b0;
		end else begin
			one_burst_rdy <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (burst_start) begin
						rd_request <= 1'b1;
						state <= RD_REQ;
					end
				end
				// request stays up until the command is taken
				RD_REQ: begin
					if (rd_addr_ack) begin
						rd_request <= 1'b0;
						state <= RD_WAIT;
					end
				end
				RD_WAIT: begin
					if (burst_land) begin
						one_burst_rdy <= 1'b1;
						state <= RD_IDLE;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// burst address scaled to beats, returned data held until the next read
	always_ff @(posedge sysclk) begin
		if (burst_start)
			rd_addr <= ddr3_addr_t'(ddr3_rd_burst_addr) * ddr3_addr_t'(`DDR3_ADDR_STEP);
		if (burst_land)
			ddr3_one_burst_data <= app_rd_data;
	end

	// reader waits for ready before the next strobe
	a_no_strobe_busy: assert property (@(posedge sysclk) disable iff (reset)
		rd_one_burst |-> state == RD_IDLE);

endmodule

//--- verilog/ddr3_addr_control.sv
module ddr3_addr_control import ddr3_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	// write side
	input  ddr3_addr_t wr_addr,
	input  logic       wr_request,
	input  logic       wr_mode,
	output logic       wr_addr_ack,
	// read side
	input  ddr3_addr_t rd_addr,
	input  logic       rd_request,
	output logic       rd_addr_ack,
	// controller command port
	input  logic       app_rdy,
	output app_addr_t  app_addr,
	output app_cmd_t   app_cmd,
	output logic       app_en
);

	typedef enum logic [1:0] {AC_IDLE, AC_CMD, AC_GAP} ac_state_t;

	ac_state_t state;
	logic      grant_wr;
	logic      grant_rd;
	logic      accepted;

	// ***********************************************************************
	// arbitration
	// ***********************************************************************
	// writes first, and nothing else while a fill is in progress
	assign grant_wr = (state == AC_IDLE) && wr_request;
	assign grant_rd = (state == AC_IDLE) && !wr_request && !wr_mode && rd_request;

	assign app_en = (state == AC_CMD);
	assign accepted = app_en && app_rdy;

	// ack in the acceptance cycle, to whichever side owns the command
	assign wr_addr_ack = accepted && (app_cmd == APP_CMD_WRITE);
	assign rd_addr_ack = accepted && (app_cmd == APP_CMD_READ);

	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= AC_IDLE;
		end else begin
			case (state)
				AC_IDLE: begin
					if (grant_wr || grant_rd)
						state <= AC_CMD;
				end
				AC_CMD: begin
					if (app_rdy)
						state <= AC_GAP;
				end
				// requester drops its request here
				AC_GAP: state <= AC_IDLE;
				default: state <= AC_IDLE;
			endcase
		end
	end

	// command payload, held through back-pressure
	always_ff @(posedge sysclk) begin
		if (grant_wr) begin
			app_addr <= {1'b0, wr_addr};
			app_cmd <= APP_CMD_WRITE;
		end else if (grant_rd) begin
			app_addr <= {1'b0, rd_addr};
			app_cmd <= APP_CMD_READ;
		end
	end

	// pending command still carries the address its requester holds
	a_wr_addr_held: assert property (@(posedge sysclk) disable iff (reset)
		app_en && app_cmd == APP_CMD_WRITE |-> app_addr == {1'b0, wr_addr});
	a_rd_addr_held: assert property (@(posedge sysclk) disable iff (reset)
		app_en && app_cmd == APP_CMD_READ |-> app_addr == {1'b0, rd_addr});

endmodule

//--- verilog/fill_header_fifo.sv
`include "ddr3_macros.svh"

module fill_header_fifo import ddr3_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	input  ddr3_word_t din,
	input  logic       wr_en,
	input  logic       rd_en,
	output ddr3_word_t dout,
	output logic       full,
	output logic       empty
);

	localparam int DEPTH = `DDR3_HDR_DEPTH;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	ddr3_word_t          mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_wr;
	logic                do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign full = (count == CNT_BITS'(DEPTH));
	assign empty = (count == '0);
	// first word fall through
	assign dout = mem[rd_ptr];

	// pointers and occupancy
	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge sysclk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	a_no_overflow: assert property (@(posedge sysclk) disable iff (reset) wr_en |-> !full);
	a_no_underflow: assert property (@(posedge sysclk) disable iff (reset) rd_en |-> !empty);

endmodule

//--- verilog/ddr3_intf.sv
`include "ddr3_macros.svh"

module ddr3_intf import ddr3_pkg::*; (
	input  logic                        sysclk,
	input  logic                        reset,
	// upstream data fifo
	input  logic                        ddr3_wr_fifo_empty,
	input  ddr3_word_t                  ddr3_wr_dat,
	output logic                        ddr3_wr_fifo_rd_en,
	// downstream reader, fill headers
	input  logic                        fill_header_fifo_rd_en,
	output logic                        fill_header_fifo_empty,
	output ddr3_word_t                  fill_header_fifo_out,
	// downstream reader, single bursts
	input  logic [`DDR3_BURST_BITS-1:0] ddr3_rd_burst_addr,
	input  logic                        ddr3_rd_one_burst,
	output logic                        ddr3_one_burst_rdy,
	output ddr3_word_t                  ddr3_one_burst_data,
	// controller user interface
	input  logic                        app_rdy,
	input  logic                        app_wdf_rdy,
	input  ddr3_word_t                  app_rd_data,
	input  logic                        app_rd_data_valid,
	input  logic                        app_rd_data_end,
	output app_addr_t                   app_addr,
	output app_cmd_t                    app_cmd,
	output logic                        app_en,
	output ddr3_word_t                  app_wdf_data,
	output logic                        app_wdf_wren,
	output logic                        app_wdf_end
);

	ddr3_addr_t ddr3_wr_addr;
	ddr3_addr_t ddr3_rd_addr;
	ddr3_word_t fill_header_wr_dat;
	logic       fill_header_wr_en;
	logic       fill_header_full;
	logic       wr_request;
	logic       wr_mode;
	logic       wr_addr_ack;
	logic       rd_request;
	logic       rd_addr_ack;

	// fifo head is the write data, popped only after acceptance
	assign app_wdf_data = ddr3_wr_dat;

	// ***********************************************************************
	// input side, fifo drain
	// ***********************************************************************
	ddr3_wr_control u_wr_control (
		.sysclk             (sysclk),
		.reset              (reset),
		.ddr3_wr_dat        (ddr3_wr_dat),
		.ddr3_wr_fifo_empty (ddr3_wr_fifo_empty),
		.ddr3_wr_fifo_rd_en (ddr3_wr_fifo_rd_en),
		.app_wdf_rdy        (app_wdf_rdy),
		.app_wdf_wren       (app_wdf_wren),
		.app_wdf_end        (app_wdf_end),
		.wr_addr_ack        (wr_addr_ack),
		.ddr3_wr_addr       (ddr3_wr_addr),
		.wr_request         (wr_request),
		.wr_mode            (wr_mode),
		.fill_header_full   (fill_header_full),
		.fill_header_wr_dat (fill_header_wr_dat),
		.fill_header_wr_en  (fill_header_wr_en)
	);

	// command port arbiter
	ddr3_addr_control u_addr_control (
		.sysclk      (sysclk),
		.reset       (reset),
		.wr_addr     (ddr3_wr_addr),
		.wr_request  (wr_request),
		.wr_mode     (wr_mode),
		.wr_addr_ack (wr_addr_ack),
		.rd_addr     (ddr3_rd_addr),
		.rd_request  (rd_request),
		.rd_addr_ack (rd_addr_ack),
		.app_rdy     (app_rdy),
		.app_addr    (app_addr),
		.app_cmd     (app_cmd),
		.app_en      (app_en)
	);

	// ***********************************************************************
	// output side, burst reads and stamped headers
	// ***********************************************************************
	ddr3_rd_control u_rd_control (
		.sysclk              (sysclk),
		.reset               (reset),
		.ddr3_rd_burst_addr  (ddr3_rd_burst_addr),
		.rd_one_burst        (ddr3_rd_one_burst),
		.one_burst_rdy       (ddr3_one_burst_rdy),
		.ddr3_one_burst_data (ddr3_one_burst_data),
		.rd_addr_ack         (rd_addr_ack),
		.rd_addr             (ddr3_rd_addr),
		.rd_request          (rd_request),
		.app_rd_data         (app_rd_data),
		.app_rd_data_valid   (app_rd_data_valid),
		.app_rd_data_end     (app_rd_data_end)
	);

	fill_header_fifo u_fill_header_fifo (
		.sysclk (sysclk),
		.reset  (reset),
		.din    (fill_header_wr_dat),
		.wr_en  (fill_header_wr_en),
		.rd_en  (fill_header_fifo_rd_en),
		.dout   (fill_header_fifo_out),
		.full   (fill_header_full),
		.empty  (fill_header_fifo_empty)
	);

endmodule

//--- verif/app_mem_model.sv
`include "ddr3_macros.svh"

module app_mem_model import ddr3_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	// ready throttling from the testbench
	input  logic       cmd_stall,
	input  logic       data_stall,
	// controller user interface, seen from the controller
	input  app_addr_t  app_addr,
	input  app_cmd_t   app_cmd,
	input  logic       app_en,
	input  ddr3_word_t app_wdf_data,
	input  logic       app_wdf_wren,
	output logic       app_rdy,
	output logic       app_wdf_rdy,
	output ddr3_word_t app_rd_data,
	output logic       app_rd_data_valid,
	output logic       app_rd_data_end
);

	timeunit 1ns;
	timeprecision 1ps;

	// memory keyed by user address
	ddr3_word_t  mem [int unsigned];
	int unsigned wr_addr_q[$];
	ddr3_word_t  wr_data_q[$];
	int unsigned rd_mem_addr;
	int          rd_wait;
	logic        ret;

	assign app_rdy = !cmd_stall;
	assign app_wdf_rdy = !data_stall;

	initial begin
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
		app_rd_data_end = 1'b0;
		rd_wait = 0;
		rd_mem_addr = 0;
	end

	// ***********************************************************************
	// command and data acceptance, fixed read latency
	// ***********************************************************************
	always @(posedge sysclk) begin
		ret = 1'b0;
		if (reset) begin
			wr_addr_q.delete();
			wr_data_q.delete();
			rd_wait = 0;
		end else begin
			if (rd_wait != 0) begin
				rd_wait = rd_wait - 1;
				ret = (rd_wait == 0);
			end
			if (app_en && app_rdy) begin
				if (app_cmd == APP_CMD_WRITE) begin
					wr_addr_q.push_back(app_addr);
				end else begin
					rd_mem_addr = app_addr;
					rd_wait = 4;
				end
			end
			if (app_wdf_wren && app_wdf_rdy)
				wr_data_q.push_back(app_wdf_data);
			// command and data pair up in either order
			while (wr_addr_q.size() != 0 && wr_data_q.size() != 0)
				mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();
		end
		#10;
		app_rd_data_valid = ret;
		app_rd_data_end = ret;
		if (ret)
			app_rd_data = mem.exists(rd_mem_addr) ? mem[rd_mem_addr] : '0;
	end

endmodule

//--- verif/tb_ddr3_intf.sv
`include "ddr3_macros.svh"

module tb_ddr3_intf import ddr3_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ENTRIES = 9;
	localparam int OP_RESET = 0;
	localparam int OP_FILLS = 1;
	localparam int OP_POP = 2;
	localparam int OP_READ = 3;
	localparam int OP_MID = 4;
	localparam int OP_FULL = 5;

	typedef struct {
		string name;
		int    op;
		int    arg;
		bit    check;
	} entry_t;

	logic sysclk, reset, ddr3_wr_fifo_empty, ddr3_wr_fifo_rd_en;
	logic fill_header_fifo_rd_en, fill_header_fifo_empty;
	logic ddr3_rd_one_burst, ddr3_one_burst_rdy, cmd_stall, data_stall;
	logic app_rdy, app_wdf_rdy, app_rd_data_valid, app_rd_data_end;
	logic app_en, app_wdf_wren, app_wdf_end;
	logic [`DDR3_BURST_BITS-1:0] ddr3_rd_burst_addr;
	ddr3_word_t ddr3_wr_dat, fill_header_fifo_out, ddr3_one_burst_data;
	ddr3_word_t app_rd_data, app_wdf_data;
	app_addr_t app_addr;
	app_cmd_t app_cmd;

	entry_t entries[N_ENTRIES];
	ddr3_word_t data_q[$];
	ddr3_word_t exp_hdr[$];
	ddr3_word_t exp_mem[int unsigned];
	app_cmd_t cmd_log[$];
	int unsigned addr_log[$];
	int unsigned next_addr, cmd_chk_addr, data_chk_addr;
	int pop_count;
	logic [31:0] data_rng, ready_rng;
	string cur_name;

	ddr3_intf u_dut (.*);

	app_mem_model u_mem (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input ddr3_word_t expected,
		input ddr3_word_t actual);
		assert (actual === expected) else begin
			$display("mismatch %s: expected %h actual %h", name, expected, actual);
			stop_with_fail();
		end
	endtask

	// ***********************************************************************
	// clock, ready throttling, data fifo model
	// ***********************************************************************
	initial begin
		sysclk = 1'b0;
		forever #50 sysclk = ~sysclk;
	end

	// roughly a quarter of the cycles stall each port
	always @(posedge sysclk) begin
		#10;
		ready_rng = xorshift(ready_rng);
		cmd_stall = (ready_rng[1:0] == 2'b00);
		data_stall = (ready_rng[3:2] == 2'b00);
	end

	task automatic refresh_fifo();
		ddr3_wr_fifo_empty = (data_q.size() == 0);
		ddr3_wr_dat = (data_q.size() != 0) ? data_q[0] : '0;
	endtask

	always @(posedge sysclk) begin
		if (ddr3_wr_fifo_rd_en) begin
			#10;
			void'(data_q.pop_front());
			pop_count++;
			refresh_fifo();
		end
	end

	// write commands in address order, data equal to the fifo head
	always @(posedge sysclk) begin
		if (!reset && app_en && app_rdy) begin
			cmd_log.push_back(app_cmd);
			addr_log.push_back(app_addr);
			if (app_cmd == APP_CMD_WRITE) begin
				check_word({cur_name, " cmd addr"}, cmd_chk_addr, app_addr);
				cmd_chk_addr += `DDR3_ADDR_STEP;
			end
		end
		if (!reset && app_wdf_wren && app_wdf_rdy) begin
			check_word({cur_name, " wdf data"}, exp_mem[data_chk_addr], app_wdf_data);
			// every word is a single-beat burst
			check_word({cur_name, " wdf end"}, 1'b1, app_wdf_end);
			data_chk_addr += `DDR3_ADDR_STEP;
		end
	end

	// ***********************************************************************
	// stimulus helpers
	// ***********************************************************************
	task automatic offer_fill();
		ddr3_word_t w;
		for (int i = 0; i < `DDR3_FILL_WORDS; i++) begin
			for (int k = 0; k < 4; k++) begin
				data_rng = xorshift(data_rng);
				w[k*32 +: 32] = data_rng;
			end
			// header keeps its upper bits, address in the low bits
			if (i == 0)
				exp_hdr.push_back({w[`DDR3_WORD_BITS-1:`DDR3_ADDR_BITS],
					next_addr[`DDR3_ADDR_BITS-1:0]});
			exp_mem[next_addr] = w;
			next_addr += `DDR3_ADDR_STEP;
			data_q.push_back(w);
		end
		refresh_fifo();
	endtask

	task automatic wait_pops(input int n);
		while (pop_count < n)
			@(posedge sysclk);
	endtask

	task automatic pop_header(input string name, input bit check);
		ddr3_word_t expected;
		@(posedge sysclk);
		while (fill_header_fifo_empty)
			@(posedge sysclk);
		expected = exp_hdr.pop_front();
		if (check)
			check_word({name, " header"}, expected, fill_header_fifo_out);
		#10 fill_header_fifo_rd_en = 1'b1;
		@(posedge sysclk);
		#10 fill_header_fifo_rd_en = 1'b0;
	endtask

	task automatic strobe_read(input int burst);
		@(posedge sysclk);
		#10;
		ddr3_rd_burst_addr = burst;
		ddr3_rd_one_burst = 1'b1;
		@(posedge sysclk);
		#10 ddr3_rd_one_burst = 1'b0;
	endtask

	task automatic finish_read(input string name, input int burst, input bit check);
		do
			@(posedge sysclk);
		while (!ddr3_one_burst_rdy);
		if (check)
			check_word({name, " read"}, exp_mem[burst * `DDR3_ADDR_STEP], ddr3_one_burst_data);
		// burst data held after ready
		repeat (5) @(posedge sysclk);
		if (check)
			check_word({name, " held"}, exp_mem[burst * `DDR3_ADDR_STEP], ddr3_one_burst_data);
	endtask

	// no read command between the first and last write of a fill
	task automatic check_no_read_in_fill(input string name, input int unsigned start);
		int first_i;
		int last_i;
		first_i = -1;
		last_i = -1;
		foreach (addr_log[i]) begin
			if (cmd_log[i] == APP_CMD_WRITE && addr_log[i] == start)
				first_i = i;
			if (cmd_log[i] == APP_CMD_WRITE && addr_log[i] == start + 24)
				last_i = i;
		end
		for (int i = first_i; i <= last_i; i++) begin
			assert (cmd_log[i] == APP_CMD_WRITE) else begin
				$display("%s: read command issued in the middle of a fill", name);
				stop_with_fail();
			end
		end
	endtask

	// ***********************************************************************
	// table, watchdog, main sequence
	// ***********************************************************************
	initial begin
		repeat (N_ENTRIES * 200 + 10) @(posedge sysclk);
		$display("watchdog expired, the DUT stopped responding during %s", cur_name);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		int base;
		int unsigned start;
		entries[0] = '{"reset_state", OP_RESET, 0, 1'b1};
		entries[1] = '{"write_fills", OP_FILLS, 3, 1'b1};
		entries[2] = '{"pop_headers", OP_POP, 3, 1'b1};
		entries[3] = '{"read_burst", OP_READ, 5, 1'b1};
		entries[4] = '{"read_during_fill", OP_MID, 1, 1'b1};
		entries[5] = '{"drain_headers", OP_POP, 1, 1'b1};
		entries[6] = '{"header_full", OP_FULL, 9, 1'b1};
		entries[7] = '{"pop_rest", OP_POP, 8, 1'b1};
		entries[8] = '{"read_last", OP_READ, 51, 1'b1};
		data_rng = 32'h80f7_f220;
		ready_rng = xorshift(32'h80f7_f220);
		reset = 1'b1;
		fill_header_fifo_rd_en = 1'b0;
		ddr3_rd_one_burst = 1'b0;
		ddr3_rd_burst_addr = '0;
		cmd_stall = 1'b0;
		data_stall = 1'b0;
		pop_count = 0;
		next_addr = 0;
		cmd_chk_addr = 0;
		data_chk_addr = 0;
		cur_name = "reset";
		refresh_fifo();
		repeat (3) @(posedge sysclk);
		#10 reset = 1'b0;
		foreach (entries[e]) begin
			cur_name = entries[e].name;
			case (entries[e].op)
				OP_RESET: begin
					@(posedge sysclk);
					check_word({cur_name, " app_en"}, 1'b0, app_en);
					check_word({cur_name, " app_wdf_wren"}, 1'b0, app_wdf_wren);
					check_word({cur_name, " fifo_rd_en"}, 1'b0, ddr3_wr_fifo_rd_en);
					check_word({cur_name, " burst_rdy"}, 1'b0, ddr3_one_burst_rdy);
					check_word({cur_name, " hdr_empty"}, 1'b1, fill_header_fifo_empty);
				end
				OP_FILLS: begin
					#10;
					repeat (entries[e].arg) offer_fill();
					wait_pops(entries[e].arg * `DDR3_FILL_WORDS);
				end
				OP_POP: begin
					repeat (entries[e].arg) pop_header(cur_name, entries[e].check);
				end
				OP_READ: begin
					strobe_read(entries[e].arg);
					finish_read(cur_name, entries[e].arg, entries[e].check);
				end
				OP_MID: begin
					#10;
					base = pop_count;
					start = next_addr;
					offer_fill();
					// header popped, fill now in progress
					wait_pops(base + 1);
					strobe_read(entries[e].arg);
					finish_read(cur_name, entries[e].arg, entries[e].check);
					wait_pops(base + `DDR3_FILL_WORDS);
					check_no_read_in_fill(cur_name, start);
				end
				OP_FULL: begin
					base = pop_count;
					repeat (entries[e].arg) offer_fill();
					wait_pops(base + `DDR3_HDR_DEPTH * `DDR3_FILL_WORDS);
					// ninth fill must stay parked while the header fifo is full
					repeat (30) @(posedge sysclk);
					check_word({cur_name, " pops"}, base + `DDR3_HDR_DEPTH * `DDR3_FILL_WORDS,
						pop_count);
					pop_header(cur_name, entries[e].check);
					wait_pops(base + entries[e].arg * `DDR3_FILL_WORDS);
				end
				default: begin
					$display("unknown operation in table entry %0d", e);
					stop_with_fail();
				end
			endcase
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- ddr3_intf.f
+incdir+include
verilog/ddr3_pkg.sv
verilog/ddr3_wr_control.sv
verilog/ddr3_rd_control.sv
verilog/ddr3_addr_control.sv
verilog/fill_header_fifo.sv
verilog/ddr3_intf.sv
verif/app_mem_model.sv
verif/tb_ddr3_intf.sv

//--- Makefile
# Verilator build for the DDR3 user side interface

VERILATOR ?= verilator
FLIST     ?= ddr3_intf.f
TB_TOP    ?= tb_ddr3_intf
RTL_TOP   ?= ddr3_intf
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
